//--- common/dec_gpr_rd_if.sv
`timescale 1ns/100ps

interface dec_gpr_rd_if;
  import dec_pkg::*;

  reg_addr_t i0_rs1_addr;   // four read addresses from decode
  reg_addr_t i0_rs2_addr;
  reg_addr_t i1_rs1_addr;
  reg_addr_t i1_rs2_addr;
  xdata_t    i0_rs1_data;   // same cycle read data
  xdata_t    i0_rs2_data;
  xdata_t    i1_rs1_data;
  xdata_t    i1_rs2_data;

  // decoder drives addresses
  modport dcd (
    output i0_rs1_addr, i0_rs2_addr, i1_rs1_addr, i1_rs2_addr,
    input  i0_rs1_data, i0_rs2_data, i1_rs1_data, i1_rs2_data
  );

  // register file answers
  modport rf (
    input  i0_rs1_addr, i0_rs2_addr, i1_rs1_addr, i1_rs2_addr,
    output i0_rs1_data, i0_rs2_data, i1_rs1_data, i1_rs2_data
  );

endinterface

//--- common/dec_ib_if.sv
`timescale 1ns/100ps

interface dec_ib_if;
  import dec_pkg::*;

  logic    ib0_valid;   // oldest entry present
  logic    ib1_valid;   // second entry present
  instr_t  ib0_instr;   // oldest instruction
  instr_t  ib1_instr;
  pc_t     ib0_pc;      // pc of oldest
  pc_t     ib1_pc;
  ib_cnt_t take;        // entries consumed by decode, 0..2

  // buffer side
  modport ib (
    output ib0_valid, ib1_valid,
    output ib0_instr, ib1_instr,
    output ib0_pc, ib1_pc,
    input  take
  );

  // decode side
  modport dcd (
    input  ib0_valid, ib1_valid,
    input  ib0_instr, ib1_instr,
    input  ib0_pc, ib1_pc,
    output take
  );

endinterface

//--- common/dec_pkg.sv
package dec_pkg;

  // ********************
  // widths and depths
  // ********************
  localparam int XLEN     = 32;                     // integer data width
  localparam int IB_DEPTH = 4;                      // buffer entries, fetch credits after reset
  localparam int NUM_GPR  = 32;                     // integer register count
  localparam int REG_AW   = $clog2(NUM_GPR);        // register index bits
  localparam int CNT_W    = $clog2(IB_DEPTH + 1);   // holds 0..IB_DEPTH

  // ********************
  // opcodes without rd write
  // ********************
  localparam logic [6:0] OPC_STORE  = 7'b0100011;   // sb/sh/sw
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;   // beq/bne/blt/bge...

  // ********************
  // instruction fields
  // ********************
  localparam int OPC_HI = 6;                        // major opcode
  localparam int OPC_LO = 0;
  localparam int RD_HI  = 11;                       // destination
  localparam int RD_LO  = 7;
  localparam int RS1_HI = 19;                       // source 1
  localparam int RS1_LO = 15;
  localparam int RS2_HI = 24;                       // source 2
  localparam int RS2_LO = 20;

  // ********************
  // vector types
  // ********************
  typedef logic [XLEN-1:0]   xdata_t;               // register data
  typedef logic [31:0]       instr_t;               // raw instruction word
  typedef logic [31:1]       pc_t;                  // halfword aligned pc
  typedef logic [REG_AW-1:0] reg_addr_t;            // x0..x31
  typedef logic [CNT_W-1:0]  ib_cnt_t;              // entry or credit count

endpackage

//--- decode/dec_decode_ctl.sv
`timescale 1ns/100ps

module dec_decode_ctl (
  input  logic            clk,
  input  logic            reset,
  dec_ib_if.dcd           ib,                 // two oldest buffer entries
  dec_gpr_rd_if.dcd       rd,                 // register read ports
  input  logic            exu_stall,          // hold everything
  output logic            dec_i0_valid,
  output logic            dec_i1_valid,
  output dec_pkg::instr_t dec_i0_instr,
  output dec_pkg::instr_t dec_i1_instr,
  output dec_pkg::pc_t    dec_i0_pc,
  output dec_pkg::pc_t    dec_i1_pc,
  output dec_pkg::xdata_t dec_i0_rs1_data,
  output dec_pkg::xdata_t dec_i0_rs2_data,
  output dec_pkg::xdata_t dec_i1_rs1_data,
  output dec_pkg::xdata_t dec_i1_rs2_data
);
  import dec_pkg::*;

  logic [6:0] i0_opc;          // i0 major opcode
  reg_addr_t  i0_rd;
  reg_addr_t  i0_rs1;
  reg_addr_t  i0_rs2;
  reg_addr_t  i1_rs1;
  reg_addr_t  i1_rs2;
  logic       i0_wen;          // i0 writes a real register
  logic       i1_dep;          // i1 reads i0 destination
  logic       i0_issue;
  logic       i1_issue;

  // ********************
  // field extraction
  // ********************
  assign i0_opc = ib.ib0_instr[OPC_HI:OPC_LO];
  assign i0_rd  = ib.ib0_instr[RD_HI:RD_LO];
  assign i0_rs1 = ib.ib0_instr[RS1_HI:RS1_LO];
  assign i0_rs2 = ib.ib0_instr[RS2_HI:RS2_LO];
  assign i1_rs1 = ib.ib1_instr[RS1_HI:RS1_LO];
  assign i1_rs2 = ib.ib1_instr[RS2_HI:RS2_LO];

  assign rd.i0_rs1_addr = i0_rs1;   // gpr reads same cycle
  assign rd.i0_rs2_addr = i0_rs2;
  assign rd.i1_rs1_addr = i1_rs1;
  assign rd.i1_rs2_addr = i1_rs2;

  // ********************
  // dual issue check
  // ********************
  assign i0_wen = (i0_opc != OPC_STORE) && (i0_opc != OPC_BRANCH) &&
                  (i0_rd != '0);                                // x0 never a dependency
  assign i1_dep = i0_wen && ((i1_rs1 == i0_rd) || (i1_rs2 == i0_rd));

  assign i0_issue = ib.ib0_valid & ~exu_stall;
  assign i1_issue = i0_issue & ib.ib1_valid & ~i1_dep;          // split on raw hazard

  assign ib.take = ib_cnt_t'(i0_issue) + ib_cnt_t'(i1_issue);   // 0, 1 or 2

  // ********************
  // issue stage
  // ********************
  always_ff @(posedge clk) begin
    if (reset) begin
      dec_i0_valid <= 1'b0;
      dec_i1_valid <= 1'b0;
    end else if (!exu_stall) begin
      dec_i0_valid <= i0_issue;      // drops to 0 when buffer empty
      dec_i1_valid <= i1_issue;
    end
  end

  always_ff @(posedge clk) begin
    if (!exu_stall) begin            // stall freezes payload too
      dec_i0_instr    <= ib.ib0_instr;
      dec_i0_pc       <= ib.ib0_pc;
      dec_i0_rs1_data <= rd.i0_rs1_data;
      dec_i0_rs2_data <= rd.i0_rs2_data;
      dec_i1_instr    <= ib.ib1_instr;   // meaningful only with i1 valid
      dec_i1_pc       <= ib.ib1_pc;
      dec_i1_rs1_data <= rd.i1_rs1_data;
      dec_i1_rs2_data <= rd.i1_rs2_data;
    end
  end

endmodule

//--- design/dec.sv
`timescale 1ns/100ps

module dec (
  input  logic               clk,
  input  logic               reset,               // sync, active high

  // fetch
  input  logic               ifu_valid,           // one instr per cycle, needs a credit
  input  dec_pkg::instr_t    ifu_instr,
  input  dec_pkg::pc_t       ifu_pc,
  output dec_pkg::ib_cnt_t   dec_credit_return,   // credits back to fetch

  // writeback ports
  input  logic               wb0_en,
  input  dec_pkg::reg_addr_t wb0_addr,
  input  dec_pkg::xdata_t    wb0_data,
  input  logic               wb1_en,              // wins over wb0
  input  dec_pkg::reg_addr_t wb1_addr,
  input  dec_pkg::xdata_t    wb1_data,
  input  logic               nbl_en,              // non-blocking load, lowest priority
  input  dec_pkg::reg_addr_t nbl_addr,
  input  dec_pkg::xdata_t    nbl_data,

  // issue
  input  logic               exu_stall,           // execute holds the issue stage
  output logic               dec_i0_valid,
  output dec_pkg::instr_t    dec_i0_instr,
  output dec_pkg::pc_t       dec_i0_pc,
  output dec_pkg::xdata_t    dec_i0_rs1_data,
  output dec_pkg::xdata_t    dec_i0_rs2_data,
  output logic               dec_i1_valid,        // implies dec_i0_valid
  output dec_pkg::instr_t    dec_i1_instr,
  output dec_pkg::pc_t       dec_i1_pc,
  output dec_pkg::xdata_t    dec_i1_rs1_data,
  output dec_pkg::xdata_t    dec_i1_rs2_data
);

  dec_ib_if     ib_if ();   // buffer -> decode
  dec_gpr_rd_if rd_if ();   // decode <-> gpr reads

  // ********************
  // instruction buffer
  // ********************
  dec_ib_ctl instbuff (
    .clk               (clk),
    .reset             (reset),
    .ifu_valid         (ifu_valid),
    .ifu_instr         (ifu_instr),
    .ifu_pc            (ifu_pc),
    .ib                (ib_if.ib),
    .dec_credit_return (dec_credit_return)
  );

  // ********************
  // decode and issue
  // ********************
  dec_decode_ctl decode (
    .clk             (clk),
    .reset           (reset),
    .ib              (ib_if.dcd),
    .rd              (rd_if.dcd),
    .exu_stall       (exu_stall),
    .dec_i0_valid    (dec_i0_valid),
    .dec_i1_valid    (dec_i1_valid),
    .dec_i0_instr    (dec_i0_instr),
    .dec_i1_instr    (dec_i1_instr),
    .dec_i0_pc       (dec_i0_pc),
    .dec_i1_pc       (dec_i1_pc),
    .dec_i0_rs1_data (dec_i0_rs1_data),
    .dec_i0_rs2_data (dec_i0_rs2_data),
    .dec_i1_rs1_data (dec_i1_rs1_data),
    .dec_i1_rs2_data (dec_i1_rs2_data)
  );

  // ********************
  // integer register file
  // ********************
  dec_gpr_ctl int_rf (
    .clk      (clk),
    .reset    (reset),
    .rd       (rd_if.rf),
    .wb0_en   (wb0_en),
    .wb1_en   (wb1_en),
    .nbl_en   (nbl_en),
    .wb0_addr (wb0_addr),
    .wb1_addr (wb1_addr),
    .nbl_addr (nbl_addr),
    .wb0_data (wb0_data),
    .wb1_data (wb1_data),
    .nbl_data (nbl_data)
  );

endmodule

//--- design/dec_gpr_ctl.sv
`timescale 1ns/100ps

module dec_gpr_ctl (
  input  logic               clk,
  input  logic               reset,
  dec_gpr_rd_if.rf           rd,          // four read ports
  input  logic               wb0_en,
  input  logic               wb1_en,
  input  logic               nbl_en,
  input  dec_pkg::reg_addr_t wb0_addr,
  input  dec_pkg::reg_addr_t wb1_addr,
  input  dec_pkg::reg_addr_t nbl_addr,
  input  dec_pkg::xdata_t    wb0_data,
  input  dec_pkg::xdata_t    wb1_data,
  input  dec_pkg::xdata_t    nbl_data
);
  import dec_pkg::*;

  xdata_t gpr_q [NUM_GPR];     // x0 slot stays zero

  // x0 hardwired on read
  function automatic xdata_t gpr_rd(input reg_addr_t addr);
    gpr_rd = (addr == '0) ? '0 : gpr_q[addr];
  endfunction

  // ********************
  // write ports
  // ********************
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NUM_GPR; i++) begin
        gpr_q[i] <= '0;
      end
    end else begin
      for (int i = 1; i < NUM_GPR; i++) begin   // skip x0
        if (wb1_en && (wb1_addr == reg_addr_t'(i))) begin
          gpr_q[i] <= wb1_data;                 // highest priority
        end else if (wb0_en && (wb0_addr == reg_addr_t'(i))) begin
          gpr_q[i] <= wb0_data;
        end else if (nbl_en && (nbl_addr == reg_addr_t'(i))) begin
          gpr_q[i] <= nbl_data;                 // late load data last
        end
      end
    end
  end

  // ********************
  // read ports
  // ********************
  assign rd.i0_rs1_data = gpr_rd(rd.i0_rs1_addr);   // no write bypass
  assign rd.i0_rs2_data = gpr_rd(rd.i0_rs2_addr);
  assign rd.i1_rs1_data = gpr_rd(rd.i1_rs1_addr);
  assign rd.i1_rs2_data = gpr_rd(rd.i1_rs2_addr);

endmodule

//--- ib/dec_ib_ctl.sv
`timescale 1ns/100ps

module dec_ib_ctl (
  input  logic             clk,
  input  logic             reset,
  input  logic             ifu_valid,           // fetch word this cycle
  input  dec_pkg::instr_t  ifu_instr,
  input  dec_pkg::pc_t     ifu_pc,
  dec_ib_if.ib             ib,                  // head entries to decode
  output dec_pkg::ib_cnt_t dec_credit_return    // one per entry taken
);
  import dec_pkg::*;

  instr_t  instr_q [IB_DEPTH];   // entry 0 is oldest
  pc_t     pc_q    [IB_DEPTH];
  ib_cnt_t count_q;              // valid entries

  instr_t  instr_d [IB_DEPTH];
  pc_t     pc_d    [IB_DEPTH];
  ib_cnt_t left;                 // entries that stay after take
  ib_cnt_t count_d;

  assign left    = count_q - ib.take;             // take never exceeds count
  assign count_d = left + ib_cnt_t'(ifu_valid);   // credits keep this <= IB_DEPTH

  // ********************
  // shift and append
  // ********************
  always_comb begin
    for (int i = 0; i < IB_DEPTH; i++) begin
      instr_d[i] = instr_q[i];                    // default hold, stale slots are don't care
      pc_d[i]    = pc_q[i];
      if ((i + int'(ib.take)) < IB_DEPTH) begin   // move down by take
        instr_d[i] = instr_q[i + int'(ib.take)];
        pc_d[i]    = pc_q[i + int'(ib.take)];
      end
      if (ifu_valid && (ib_cnt_t'(i) == left)) begin   // new word right behind survivors
        instr_d[i] = ifu_instr;
        pc_d[i]    = ifu_pc;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      count_q <= '0;              // empty buffer
    end else begin
      count_q <= count_d;
    end
  end

  always_ff @(posedge clk) begin
    instr_q <= instr_d;           // payload only, qualified by count_q
    pc_q    <= pc_d;
  end

  // ********************
  // head to decode
  // ********************
  assign ib.ib0_valid = (count_q != '0);
  assign ib.ib1_valid = (count_q > ib_cnt_t'(1));
  assign ib.ib0_instr = instr_q[0];
  assign ib.ib1_instr = instr_q[1];
  assign ib.ib0_pc    = pc_q[0];
  assign ib.ib1_pc    = pc_q[1];

  assign dec_credit_return = ib.take;   // entry freed same cycle it is taken

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the decode slice testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f src.f --top-module tb_dec -o tb_dec_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_dec_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -qx "TB PASSED" "$LOG"; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi

//--- src.f
+incdir+test
common/dec_pkg.sv
common/dec_ib_if.sv
common/dec_gpr_rd_if.sv
ib/dec_ib_ctl.sv
decode/dec_decode_ctl.sv
design/dec_gpr_ctl.sv
design/dec.sv
test/tb_dec.sv

//--- test/dec_tests.svh
// ********************
// support tasks
// ********************

// one write cycle while nothing is in flight
task automatic gpr_write(input logic e0, input reg_addr_t a0, input xdata_t d0,
                         input logic e1, input reg_addr_t a1, input xdata_t d1,
                         input logic en, input reg_addr_t an, input xdata_t dn);
  @(negedge clk);
  assert (!dec_i0_valid && exp_q.size() == 0)
    else report_error("register write while instructions are in flight");
  exu_stall = 1'b0;
  ifu_valid = 1'b0;
  {wb0_en, wb0_addr, wb0_data} = {e0, a0, d0};
  {wb1_en, wb1_addr, wb1_data} = {e1, a1, d1};
  {nbl_en, nbl_addr, nbl_data} = {en, an, dn};
  if (en && an != '0) ref_gpr[an] = dn;   // lowest priority first so later ones win
  if (e0 && a0 != '0) ref_gpr[a0] = d0;
  if (e1 && a1 != '0) ref_gpr[a1] = d1;
  stall_q = 1'b0;
endtask

task automatic drain();
  while (send_q.size() > 0 || exp_q.size() > 0) step(1'b0, 1'b1);
  repeat (3) step(1'b0, 1'b0);            // catches duplicates
  assert (credits == IB_DEPTH)
    else report_error($sformatf("credits %0d after drain, expected %0d", credits, IB_DEPTH));
endtask

// independent op with rd in the low half and sources in the high half
function automatic instr_t indep_instr();
  return make_instr(OPC_OP, reg_addr_t'($urandom_range(15, 1)),
                    reg_addr_t'($urandom_range(31, 16)), reg_addr_t'($urandom_range(31, 16)));
endfunction

task automatic pair_issue(input instr_t i0, input instr_t i1, input logic expect_dual);
  int dual_before;
  dual_before = dual_cnt;
  add_instr(i0);
  add_instr(i1);
  repeat (3) step(1'b1, 1'b1);            // both reach the head under stall
  drain();
  if (expect_dual) begin
    assert (dual_cnt == dual_before + 1) else report_error("independent pair did not dual issue");
  end
endtask

// ********************
// directed tests
// ********************
task automatic reset_state_check();
  repeat (5) begin
    step(1'b0, 1'b0);
    assert (!dec_i0_valid && !dec_i1_valid) else report_error("issue valid set after reset");
    assert (dec_credit_return == '0) else report_error("credit return set after reset");
  end
endtask

task automatic regfile_writes();
  for (int r = 1; r < NUM_GPR; r++) begin
    gpr_write(1'b1, reg_addr_t'(r), $urandom(), 1'b0, '0, '0, 1'b0, '0, '0);
  end
  gpr_write(1'b1, 5'd5, $urandom(), 1'b1, 5'd5, $urandom(), 1'b1, 5'd5, $urandom());
  gpr_write(1'b1, 5'd6, $urandom(), 1'b0, '0, '0, 1'b1, 5'd6, $urandom());
  gpr_write(1'b0, '0, '0, 1'b0, '0, '0, 1'b1, 5'd7, $urandom());
  gpr_write(1'b1, 5'd8, $urandom(), 1'b1, 5'd0, $urandom(), 1'b0, '0, '0);   // x0 ignored
  gpr_write(1'b0, '0, '0, 1'b1, 5'd0, $urandom(), 1'b1, 5'd9, $urandom());
  add_instr(make_instr(OPC_OP, 5'd1, 5'd5, 5'd6));
  add_instr(make_instr(OPC_OP, 5'd2, 5'd7, 5'd0));
  add_instr(make_instr(OPC_STORE, 5'd0, 5'd8, 5'd9));
  add_instr(make_instr(OPC_OP, 5'd0, 5'd0, 5'd5));
  drain();
endtask

task automatic inorder_flow();
  int returned_before;
  returned_before = returned;
  repeat (16) add_instr(indep_instr());
  drain();
  assert (returned - returned_before == 16)
    else report_error($sformatf("%0d credits returned for 16 words", returned - returned_before));
endtask

task automatic dependency_split();
  pair_issue(make_instr(OPC_OP, 5'd3, 5'd20, 5'd21), make_instr(OPC_OP, 5'd12, 5'd3, 5'd10), 0);
  pair_issue(make_instr(OPC_OP, 5'd4, 5'd22, 5'd23), make_instr(OPC_STORE, 5'd0, 5'd11, 5'd4), 0);
  pair_issue(make_instr(OPC_STORE, 5'd3, 5'd24, 5'd25), make_instr(OPC_OP, 5'd13, 5'd3, 5'd26), 1);
  pair_issue(make_instr(OPC_BRANCH, 5'd4, 5'd27, 5'd28), make_instr(OPC_OP, 5'd14, 5'd29, 5'd4), 1);
  pair_issue(make_instr(OPC_OP, 5'd0, 5'd30, 5'd31), make_instr(OPC_OP, 5'd15, 5'd0, 5'd0), 1);
endtask

task automatic back_pressure();
  repeat (10) add_instr(indep_instr());
  repeat (3) step(1'b0, 1'b1);            // a few reach the issue stage
  repeat (12) step(1'b1, 1'b1);           // fetch runs dry on credits
  assert (send_q.size() == 4) else report_error("fetch sent words without credits");
  drain();
endtask

task automatic random_mix();
  logic [6:0] opc [4];
  opc = '{OPC_OP, OPC_LOAD, OPC_STORE, OPC_BRANCH};
  repeat (40) begin
    add_instr(make_instr(opc[$urandom_range(3, 0)], reg_addr_t'($urandom_range(31, 0)),
                         reg_addr_t'($urandom_range(31, 0)), reg_addr_t'($urandom_range(31, 0))));
  end
  while (send_q.size() > 0 || exp_q.size() > 0) begin
    step($urandom_range(3, 0) == 0, $urandom_range(3, 0) != 0);   // stalls and fetch gaps
  end
  drain();
endtask

//--- test/tb_dec.sv
`timescale 1ns/100ps

module tb_dec;
  import dec_pkg::*;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 10;
  localparam int N_INSTR      = 80;                     // fetched over all tests
  localparam int WD_CYCLES    = 200 * N_INSTR + 1000;   // per instruction budget plus margin
  localparam logic [6:0] OPC_OP   = 7'b0110011;         // reg-reg alu
  localparam logic [6:0] OPC_LOAD = 7'b0000011;

  logic      clk = 1'b0;
  logic      reset;
  logic      ifu_valid;
  instr_t    ifu_instr;
  pc_t       ifu_pc;
  ib_cnt_t   dec_credit_return;
  logic      wb0_en;
  reg_addr_t wb0_addr;
  xdata_t    wb0_data;
  logic      wb1_en;
  reg_addr_t wb1_addr;
  xdata_t    wb1_data;
  logic      nbl_en;
  reg_addr_t nbl_addr;
  xdata_t    nbl_data;
  logic      exu_stall;
  logic      dec_i0_valid;
  instr_t    dec_i0_instr;
  pc_t       dec_i0_pc;
  xdata_t    dec_i0_rs1_data;
  xdata_t    dec_i0_rs2_data;
  logic      dec_i1_valid;
  instr_t    dec_i1_instr;
  pc_t       dec_i1_pc;
  xdata_t    dec_i1_rs1_data;
  xdata_t    dec_i1_rs2_data;

  // ********************
  // reference models
  // ********************
  int           credits;              // fetch side credit counter
  int           returned;             // credits seen so far
  int           dual_cnt;             // pairs consumed together
  xdata_t       ref_gpr [NUM_GPR];    // expected register contents
  instr_t       send_q [$];           // waiting for a credit
  pc_t          send_pc_q [$];
  instr_t       exp_q [$];            // fetched and not yet issued
  pc_t          exp_pc_q [$];
  pc_t          next_pc;
  logic         stall_q;              // stall of the previous cycle
  logic [255:0] out_q;                // issue outputs of the previous cycle

  always #(CLK_PERIOD / 2) clk = ~clk;

  dec dec_inst (.*);

  initial begin
    #(CLK_PERIOD * WD_CYCLES);
    $display("Watchdog timeout: the tests did not finish within %0d cycles", WD_CYCLES);
    $display("TB FAILED");
    $fatal(1, "watchdog");
  end

  task automatic report_error(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    $display("TB FAILED");
    $fatal(1, "stopped at first error");
  endtask

  function automatic instr_t make_instr(input logic [6:0] opc, input reg_addr_t rd,
                                        input reg_addr_t rs1, input reg_addr_t rs2);
    return {7'b0, rs2, rs1, 3'b000, rd, opc};   // r-type layout
  endfunction

  function automatic xdata_t gpr_value(input reg_addr_t addr);
    return (addr == '0) ? '0 : ref_gpr[addr];   // x0 reads zero
  endfunction

  // younger reads what the older one writes
  function automatic logic depends(input instr_t i0, input instr_t i1);
    logic [6:0] opc;
    reg_addr_t  rd;
    opc = i0[OPC_HI:OPC_LO];
    rd  = i0[RD_HI:RD_LO];
    return (opc != OPC_STORE) && (opc != OPC_BRANCH) && (rd != '0) &&
           ((i1[RS1_HI:RS1_LO] == rd) || (i1[RS2_HI:RS2_LO] == rd));
  endfunction

  task automatic add_instr(input instr_t instr);
    send_q.push_back(instr);
    send_pc_q.push_back(next_pc);
    next_pc = next_pc + pc_t'(2);   // 4 bytes in halfword units
  endtask

  task automatic check_issue(input instr_t instr, input pc_t pc,
                             input xdata_t rs1_data, input xdata_t rs2_data);
    instr_t exp_instr;
    pc_t    exp_pc;
    assert (exp_q.size() > 0) else report_error("instruction issued that was never fetched");
    exp_instr = exp_q.pop_front();
    exp_pc    = exp_pc_q.pop_front();
    assert (instr == exp_instr)
      else report_error($sformatf("instr %h, expected %h", instr, exp_instr));
    assert (pc == exp_pc) else report_error($sformatf("pc %h, expected %h", pc, exp_pc));
    assert (rs1_data == gpr_value(exp_instr[RS1_HI:RS1_LO]))
      else report_error($sformatf("rs1 data %h for instr %h", rs1_data, exp_instr));
    assert (rs2_data == gpr_value(exp_instr[RS2_HI:RS2_LO]))
      else report_error($sformatf("rs2 data %h for instr %h", rs2_data, exp_instr));
  endtask

  // drive one cycle on the falling edge and check what execute consumes
  task automatic step(input logic stall, input logic fetch_en);
    logic [255:0] out_now;
    @(negedge clk);
    out_now = {dec_i0_valid, dec_i1_valid, dec_i0_instr, dec_i1_instr, dec_i0_pc, dec_i1_pc,
               dec_i0_rs1_data, dec_i0_rs2_data, dec_i1_rs1_data, dec_i1_rs2_data};
    if (stall_q) begin
      assert (out_now == out_q) else report_error("issue outputs changed under exu_stall");
    end
    wb0_en    = 1'b0;
    wb1_en    = 1'b0;
    nbl_en    = 1'b0;
    exu_stall = stall;
    ifu_valid = 1'b0;
    if (fetch_en && credits > 0 && send_q.size() > 0) begin
      ifu_valid = 1'b1;
      ifu_instr = send_q.pop_front();
      ifu_pc    = send_pc_q.pop_front();
      exp_q.push_back(ifu_instr);
      exp_pc_q.push_back(ifu_pc);
      credits--;                                 // one credit per word
    end
    #1;                                          // let the credit return settle
    if (stall) begin
      assert (dec_credit_return == '0)
        else report_error($sformatf("credit return %0d under stall", dec_credit_return));
    end
    credits  += int'(dec_credit_return);
    returned += int'(dec_credit_return);
    assert (credits <= IB_DEPTH) else report_error($sformatf("credits grew to %0d", credits));
    assert (!dec_i1_valid || dec_i0_valid) else report_error("i1 valid without i0 valid");
    if (!stall && dec_i0_valid) begin            // consumed at the next edge
      check_issue(dec_i0_instr, dec_i0_pc, dec_i0_rs1_data, dec_i0_rs2_data);
      if (dec_i1_valid) begin
        check_issue(dec_i1_instr, dec_i1_pc, dec_i1_rs1_data, dec_i1_rs2_data);
        assert (!depends(dec_i0_instr, dec_i1_instr))
          else report_error("dependent pair issued together");
        dual_cnt++;
      end
    end
    out_q   = out_now;
    stall_q = stall;
  endtask

  `include "dec_tests.svh"

  initial begin
    void'($urandom(32'h4357c2d3));
    reset     = 1'b1;
    ifu_valid = 1'b0;
    ifu_instr = '0;
    ifu_pc    = '0;
    {wb0_en, wb0_addr, wb0_data} = '0;
    {wb1_en, wb1_addr, wb1_data} = '0;
    {nbl_en, nbl_addr, nbl_data} = '0;
    exu_stall = 1'b0;
    credits   = IB_DEPTH;                        // buffer starts empty
    returned  = 0;
    dual_cnt  = 0;
    next_pc   = pc_t'(32'h0000_0800);
    stall_q   = 1'b0;
    out_q     = '0;
    for (int i = 0; i < NUM_GPR; i++) begin
      ref_gpr[i] = '0;
    end
    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b0;
    reset_state_check();
    regfile_writes();
    inorder_flow();
    dependency_split();
    back_pressure();
    random_mix();
    $display("TB PASSED");
    $finish;
  end

endmodule
